/* build.f */
fixed_point_pkg.sv
lzc.sv
recip_prescale.sv
recip_seed.sv
recip_refine.sv
recip_postscale.sv
recip_cfg.sv
recip_unit.sv
tb_clk_gen.sv
recip_unit_chk.sv
recip_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the recip_unit testbench with Verilator.
# The exit status is nonzero when compilation or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module recip_unit_tb -Mdir obj_dir -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit "$status"
fi

./obj_dir/Vrecip_unit_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished"
exit 0

/* recip_unit_tb.sv */
/*
  Directed tests for recip_unit against a real-valued model of 2^20 / x, clipped to FIX_MAX.
  Stops at the first failed check; the configuration is only written while the pipeline is idle.
*/
`timescale 1ns/100ps

module recip_unit_tb;

  import fixed_point_pkg::*;

  localparam logic [31:0] SEED = 32'h8e197bd0;
  // the tests take about 400 cycles including reset and drains
  localparam int  TIMEOUT_CYCLES = 2000;
  localparam real TOL_REFINED    = 1.0 / 128.0;
  localparam real TOL_SEED       = 1.0 / 17.0;

  logic clk;
  logic rst;
  logic in_valid;
  fix_t in_data;
  logic out_valid;
  fix_t out_data;
  logic out_sat;
  logic cfg_we;
  logic cfg_refine;
  logic refine_en;
  logic sat_sticky;

  // inputs still in flight and the mode each was sent in, oldest first
  fix_t exp_in_q[$];
  bit   exp_mode_q[$];
  bit   mode_refine;
  int   cycle_count = 0;
  int   outside_refined_band;

  tb_clk_gen #(
    .PERIOD       (10),
    .RESET_CYCLES (16)
  ) u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  recip_unit u_dut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_sat    (out_sat),
    .cfg_we     (cfg_we),
    .cfg_refine (cfg_refine),
    .refine_en  (refine_en),
    .sat_sticky (sat_sticky)
  );

  bind recip_unit recip_unit_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_sat    (out_sat),
    .out_data   (out_data),
    .cfg_we     (cfg_we),
    .sat_sticky (sat_sticky)
  );

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on the first failed check");
  endtask

  function automatic real abs_real(input real v);
    return (v < 0.0) ? -v : v;
  endfunction

  // zero maps to +FIX_MAX, everything else is 2^20 / x clipped to full scale
  function automatic real ideal_recip(input fix_t x);
    real r;
    if (x == 0) begin
      return real'(FIX_MAX);
    end
    r = 1048576.0 / real'(x);
    if (r > real'(FIX_MAX)) begin
      r = real'(FIX_MAX);
    end else if (r < -real'(FIX_MAX)) begin
      r = -real'(FIX_MAX);
    end
    return r;
  endfunction

  function automatic bit expect_sat(input fix_t x);
    if (x == 0) begin
      return 1'b1;
    end
    return abs_real(1048576.0 / real'(x)) > real'(FIX_MAX);
  endfunction

  // spread the magnitudes over all shift counts, never below min_mag
  function automatic fix_t random_input(input int min_mag);
    logic [18:0] mag;
    mag = 19'($urandom) >> ($urandom % 19);
    if (mag < 19'(min_mag)) begin
      mag = 19'(min_mag);
    end
    return ($urandom % 2) ? -fix_t'({1'b0, mag}) : fix_t'({1'b0, mag});
  endfunction

  task automatic check_output();
    fix_t x;
    bit   refined;
    real  ideal;
    real  tol;
    real  err;
    assert (exp_in_q.size() != 0) else begin
      $display("an output appeared at %0t with no input outstanding", $time);
      abort_run();
    end
    x       = exp_in_q.pop_front();
    refined = exp_mode_q.pop_front();
    ideal   = ideal_recip(x);
    tol     = (refined ? TOL_REFINED : TOL_SEED) * abs_real(ideal) + 1.0;
    err     = abs_real(real'(out_data) - ideal);
    assert (err <= tol) else begin
      $display("mismatch at %0t: input %0d gave %0d, ideal %0.2f, allowed error %0.2f",
               $time, x, out_data, ideal, tol);
      abort_run();
    end
    assert (out_sat == expect_sat(x)) else begin
      $display("mismatch at %0t: input %0d gave out_sat %b", $time, x, out_sat);
      abort_run();
    end
    if (!refined && (err > TOL_REFINED * abs_real(ideal) + 1.0)) begin
      outside_refined_band++;
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      check_output();
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  task automatic send_item(input fix_t x);
    in_valid = 1'b1;
    in_data  = x;
    exp_in_q.push_back(x);
    exp_mode_q.push_back(mode_refine);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_in_q.size() != 0) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic write_cfg(input bit refine);
    cfg_we      = 1'b1;
    cfg_refine  = refine;
    mode_refine = refine;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic test_after_reset();
    assert ({refine_en, out_valid, sat_sticky} == 3'b100) else begin
      $display("mismatch at %0t: refine_en %b out_valid %b sat_sticky %b after reset",
               $time, refine_en, out_valid, sat_sticky);
      abort_run();
    end
  endtask

  task automatic test_exact_powers();
    // 1.0, -1.0, 2.0, -2.0, 0.5, 4.0 and the most negative word
    fix_t vals[7] = '{fix_t'(1024), fix_t'(-1024), fix_t'(2048), fix_t'(-2048),
                      fix_t'(512), fix_t'(4096), fix_t'(-524288)};
    foreach (vals[i]) begin
      send_item(vals[i]);
    end
    wait_idle();
  endtask

  task automatic test_refined_random();
    repeat (200) begin
      send_item(random_input(3));
    end
    wait_idle();
  endtask

  // the rounded seed constants overshoot 1/17 by a hair, visible only for tiny inputs
  task automatic test_seed_only();
    write_cfg(1'b0);
    outside_refined_band = 0;
    repeat (100) begin
      send_item(random_input(16));
    end
    wait_idle();
    assert (outside_refined_band > 0) else begin
      $display("seed-only mode gave no result outside the refined error band");
      abort_run();
    end
    write_cfg(1'b1);
  endtask

  task automatic test_saturation();
    send_item(fix_t'(0));
    send_item(fix_t'(1));
    send_item(fix_t'(-1));
    wait_idle();
    assert (sat_sticky == 1'b1) else begin
      $display("mismatch at %0t: sat_sticky is %b after saturated results", $time, sat_sticky);
      abort_run();
    end
  endtask

  task automatic test_sticky_clear();
    write_cfg(1'b1);
    assert (sat_sticky == 1'b0) else begin
      $display("mismatch at %0t: sat_sticky is %b after a write", $time, sat_sticky);
      abort_run();
    end
    send_item(fix_t'(1536));
    wait_idle();
    assert (sat_sticky == 1'b0) else begin
      $display("mismatch at %0t: sat_sticky is %b after a normal input", $time, sat_sticky);
      abort_run();
    end
  endtask

  initial begin
    in_valid             = 1'b0;
    in_data              = '0;
    cfg_we               = 1'b0;
    cfg_refine           = 1'b1;
    mode_refine          = 1'b1;
    outside_refined_band = 0;
    void'($urandom(SEED));
    @(negedge rst);
    test_after_reset();
    test_exact_powers();
    test_refined_random();
    test_seed_only();
    test_saturation();
    test_sticky_clear();
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* recip_unit_chk.sv */
/*
  Bound checks on the top-level strobes, saturation output and sticky flag.
  Assumes the fixed 4-cycle latency of recip_unit.
*/
`timescale 1ns/100ps

module recip_unit_chk (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic                     out_valid,
  input  logic                     out_sat,
  input  fixed_point_pkg::fix_t    out_data,
  input  logic                     cfg_we,
  input  logic                     sat_sticky
);

  import fixed_point_pkg::*;

  localparam int LATENCY = 4;

  // one output per input, exactly LATENCY edges later
  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, LATENCY))
    else $error("out_valid does not follow in_valid by %0d cycles", LATENCY);

  a_sat_valid: assert property (@(posedge clk) disable iff (rst)
    out_sat |-> out_valid)
    else $error("out_sat is high without out_valid");

  // a saturated result is always the full-scale magnitude
  a_sat_value: assert property (@(posedge clk) disable iff (rst)
    out_sat |-> ((out_data == FIX_MAX) || (out_data == fix_t'(-FIX_MAX))))
    else $error("out_sat is high but out_data is not full scale");

  a_clear_on_write: assert property (@(posedge clk) disable iff (rst)
    $past(cfg_we) |-> !sat_sticky)
    else $error("sat_sticky is still set after a configuration write");

  // the flag is only set on the edge that registers out_sat
  a_set_by_sat: assert property (@(posedge clk) disable iff (rst)
    $rose(sat_sticky) |-> out_sat)
    else $error("sat_sticky rose without a saturated output");

endmodule

/* tb_clk_gen.sv */
/*
  Free-running testbench clock with a synchronous, active-high reset.
  Reset drops 1 ns after the last of its RESET_CYCLES rising edges.
*/
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk = ~clk;
    end
  end

  // same offset as the other driven inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

/* recip_unit.sv */
/*
  Pipelined Q10.10 reciprocal, 4 cycles from in_valid to out_valid, no stalls.
  Change the configuration only while the pipeline is empty.
*/
`timescale 1ns/100ps

module recip_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  fixed_point_pkg::fix_t    in_data,
  output logic                     out_valid,
  output fixed_point_pkg::fix_t    out_data,
  output logic                     out_sat,
  input  logic                     cfg_we,
  input  logic                     cfg_refine,
  output logic                     refine_en,
  output logic                     sat_sticky
);

  import fixed_point_pkg::*;

  logic   pre_valid, pre_sign, pre_zero;
  lzc_t   pre_count;
  mant_t  pre_mant;

  logic   seed_valid, seed_sign, seed_zero;
  lzc_t   seed_count;
  mant_t  seed_mant;
  rmant_t seed_recip;

  logic   ref_valid, ref_sign, ref_zero;
  lzc_t   ref_count;
  rmant_t ref_recip;

  logic   sat_event;

  recip_cfg u_cfg (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_refine (cfg_refine),
    .sat_event  (sat_event),
    .refine_en  (refine_en),
    .sat_sticky (sat_sticky)
  );

  recip_prescale #(
    .WIDTH (FIX_W)
  ) u_prescale (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .pre_valid (pre_valid),
    .pre_sign  (pre_sign),
    .pre_zero  (pre_zero),
    .pre_count (pre_count),
    .pre_mant  (pre_mant)
  );

  recip_seed u_seed (
    .clk        (clk),
    .rst        (rst),
    .pre_valid  (pre_valid),
    .pre_sign   (pre_sign),
    .pre_zero   (pre_zero),
    .pre_count  (pre_count),
    .pre_mant   (pre_mant),
    .seed_valid (seed_valid),
    .seed_sign  (seed_sign),
    .seed_zero  (seed_zero),
    .seed_count (seed_count),
    .seed_mant  (seed_mant),
    .seed_recip (seed_recip)
  );

  recip_refine u_refine (
    .clk        (clk),
    .rst        (rst),
    .refine_en  (refine_en),
    .seed_valid (seed_valid),
    .seed_sign  (seed_sign),
    .seed_zero  (seed_zero),
    .seed_count (seed_count),
    .seed_mant  (seed_mant),
    .seed_recip (seed_recip),
    .ref_valid  (ref_valid),
    .ref_sign   (ref_sign),
    .ref_zero   (ref_zero),
    .ref_count  (ref_count),
    .ref_recip  (ref_recip)
  );

  recip_postscale u_postscale (
    .clk       (clk),
    .rst       (rst),
    .ref_valid (ref_valid),
    .ref_sign  (ref_sign),
    .ref_zero  (ref_zero),
    .ref_count (ref_count),
    .ref_recip (ref_recip),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_sat   (out_sat),
    .sat_event (sat_event)
  );

endmodule

/* recip_cfg.sv */
/*
  Refine mode register and sticky saturation flag.
  A cfg_we write clears the flag and wins over a set in the same cycle.
*/
`timescale 1ns/100ps

module recip_cfg (
  input  logic clk,
  input  logic rst,
  input  logic cfg_we,
  input  logic cfg_refine,
  input  logic sat_event,
  output logic refine_en,
  output logic sat_sticky
);

  // refinement is on out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      refine_en <= 1'b1;
    end else if (cfg_we) begin
      refine_en <= cfg_refine;
    end
  end

  // set lands on the same edge as out_sat
  always_ff @(posedge clk) begin
    if (rst) begin
      sat_sticky <= 1'b0;
    end else if (cfg_we) begin
      sat_sticky <= 1'b0;
    end else if (sat_event) begin
      sat_sticky <= 1'b1;
    end
  end

endmodule

/* recip_postscale.sv */
/*
  Last stage: raw result = recip * 2^(count - 16), truncated, then saturated and signed.
  sat_event is combinational and only valid together with ref_valid.
*/
`timescale 1ns/100ps

module recip_postscale (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ref_valid,
  input  logic                     ref_sign,
  input  logic                     ref_zero,
  input  fixed_point_pkg::lzc_t    ref_count,
  input  fixed_point_pkg::rmant_t  ref_recip,
  output logic                     out_valid,
  output fixed_point_pkg::fix_t    out_data,
  output logic                     out_sat,
  output logic                     sat_event
);

  import fixed_point_pkg::*;

  // room for an 18-bit mantissa shifted by up to 20
  localparam int SCALE_W = 40;

  logic [SCALE_W-1:0]            scaled;
  logic [SCALE_W-RECIP_FRAC-1:0] shifted;
  logic                          ovf;
  logic                          sat;
  fix_t                          mag;
  fix_t                          result;

  // shift left by count, then drop the 16 reciprocal fraction bits
  assign scaled  = SCALE_W'(ref_recip) << ref_count;
  assign shifted = scaled[SCALE_W-1:RECIP_FRAC];
  assign ovf     = (shifted > (SCALE_W - RECIP_FRAC)'(FIX_MAX));

  assign sat    = ref_zero | ovf;
  assign mag    = sat ? FIX_MAX : fix_t'(shifted[FIX_W-1:0]);
  assign result = ref_sign ? -mag : mag;

  assign sat_event = ref_valid & sat;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_sat   <= 1'b0;
    end else begin
      out_valid <= ref_valid;
      out_sat   <= sat_event;
    end
  end

  always_ff @(posedge clk) begin
    out_data <= result;
  end

endmodule

/* recip_refine.sv */
/*
  Third stage: one optional Newton step g * (2 - m * g), truncating both products.
  refine_en is sampled while the item is in this stage; low forwards the seed as is.
*/
`timescale 1ns/100ps

module recip_refine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     refine_en,
  input  logic                     seed_valid,
  input  logic                     seed_sign,
  input  logic                     seed_zero,
  input  fixed_point_pkg::lzc_t    seed_count,
  input  fixed_point_pkg::mant_t   seed_mant,
  input  fixed_point_pkg::rmant_t  seed_recip,
  output logic                     ref_valid,
  output logic                     ref_sign,
  output logic                     ref_zero,
  output fixed_point_pkg::lzc_t    ref_count,
  output fixed_point_pkg::rmant_t  ref_recip
);

  import fixed_point_pkg::*;

  // 2.0 in Q2.16
  localparam rmant_t TWO = rmant_t'(2 << RECIP_FRAC);

  logic [MANT_W+RECIP_FRAC+1:0]  mg_prod;
  rmant_t                        mg;
  rmant_t                        corr;
  logic [2*RECIP_FRAC+3:0]       nr_prod;
  rmant_t                        newton;

  // m * g close to 1.0 once back in Q2.16
  assign mg_prod = seed_mant * seed_recip;
  assign mg      = rmant_t'(mg_prod >> MANT_W);
  assign corr    = TWO - mg;

  // newton undershoots 1/m, so the result stays below 2.0
  assign nr_prod = seed_recip * corr;
  assign newton  = rmant_t'(nr_prod >> RECIP_FRAC);

  always_ff @(posedge clk) begin
    if (rst) begin
      ref_valid <= 1'b0;
    end else begin
      ref_valid <= seed_valid;
    end
  end

  always_ff @(posedge clk) begin
    ref_sign  <= seed_sign;
    ref_zero  <= seed_zero;
    ref_count <= seed_count;
    ref_recip <= refine_en ? newton : seed_recip;
  end

endmodule

/* recip_seed.sv */
/*
  Second stage: linear first guess 48/17 - 32/17 * m of 1/m for m in [0.5, 1).
  Relative error of the guess stays below 1/17; the result is truncated to Q2.16.
*/
`timescale 1ns/100ps

module recip_seed (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pre_valid,
  input  logic                     pre_sign,
  input  logic                     pre_zero,
  input  fixed_point_pkg::lzc_t    pre_count,
  input  fixed_point_pkg::mant_t   pre_mant,
  output logic                     seed_valid,
  output logic                     seed_sign,
  output logic                     seed_zero,
  output fixed_point_pkg::lzc_t    seed_count,
  output fixed_point_pkg::mant_t   seed_mant,
  output fixed_point_pkg::rmant_t  seed_recip
);

  import fixed_point_pkg::*;

  // 48/17 and 32/17 in Q2.16
  localparam rmant_t      SEED_OFFSET = 18'd185043;
  localparam logic [16:0] SEED_SLOPE  = 17'd123362;

  logic [MANT_W+16:0] slope_prod;
  rmant_t             guess;

  // slope term in Q2.16 after dropping the mantissa fraction
  assign slope_prod = SEED_SLOPE * pre_mant;
  assign guess      = SEED_OFFSET - rmant_t'(slope_prod >> MANT_W);

  always_ff @(posedge clk) begin
    if (rst) begin
      seed_valid <= 1'b0;
    end else begin
      seed_valid <= pre_valid;
    end
  end

  // mantissa travels on, refine needs it for the newton step
  always_ff @(posedge clk) begin
    seed_sign  <= pre_sign;
    seed_zero  <= pre_zero;
    seed_count <= pre_count;
    seed_mant  <= pre_mant;
    seed_recip <= guess;
  end

endmodule

/* recip_prescale.sv */
/*
  First stage: magnitude, sign and normalization of the Q10.10 input.
  WIDTH is expected to equal FIX_W and MANT_W; the most negative input maps to 2^19.
*/
`timescale 1ns/100ps

module recip_prescale #(
  parameter int WIDTH = fixed_point_pkg::FIX_W
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  fixed_point_pkg::fix_t    in_data,
  output logic                     pre_valid,
  output logic                     pre_sign,
  output logic                     pre_zero,
  output fixed_point_pkg::lzc_t    pre_count,
  output fixed_point_pkg::mant_t   pre_mant
);

  import fixed_point_pkg::*;

  logic [WIDTH-1:0] mag;
  lzc_t             cnt;
  mant_t            mant;
  logic             tiny;

  // two's complement magnitude, unsigned so that -2^19 survives
  assign mag = in_data[WIDTH-1] ? (~in_data + 1'b1) : in_data;

  lzc #(
    .WIDTH (WIDTH)
  ) u_lzc (
    .data  (mag),
    .count (cnt)
  );

  // shift the leading one up to the msb, value lands in [0.5, 1)
  assign mant = mant_t'(mag << cnt);

  // zero, 1 or 2 raw LSBs have a reciprocal above FIX_MAX
  assign tiny = (mag < 3);

  always_ff @(posedge clk) begin
    if (rst) begin
      pre_valid <= 1'b0;
    end else begin
      pre_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    pre_sign  <= in_data[WIDTH-1];
    pre_zero  <= tiny;
    pre_count <= cnt;
    pre_mant  <= mant;
  end

endmodule

/* lzc.sv */
/*
  Combinational leading zero counter; an all-zero input returns WIDTH.
  WIDTH must not exceed 31 so that the count fits lzc_t.
*/
`timescale 1ns/100ps

module lzc #(
  parameter int WIDTH = fixed_point_pkg::FIX_W
) (
  input  logic [WIDTH-1:0]         data,
  output fixed_point_pkg::lzc_t    count
);

  import fixed_point_pkg::*;

  lzc_t cnt;

  // scan from the lsb upwards so the highest set bit wins
  always_comb begin
    cnt = lzc_t'(WIDTH);
    for (int i = 0; i < WIDTH; i++) begin
      if (data[i]) begin
        cnt = lzc_t'(WIDTH - 1 - i);
      end
    end
  end

  assign count = cnt;

endmodule

/* fixed_point_pkg.sv */
/*
  Q10.10 data format and the internal mantissa formats of the reciprocal pipeline.
  Widths are fixed here; only the leading zero counter takes a width parameter.
*/
package fixed_point_pkg;

  // data word format, signed Q10.10
  localparam int Q_INT  = 10;
  localparam int Q_FRAC = 10;
  localparam int FIX_W  = Q_INT + Q_FRAC;

  typedef logic signed [FIX_W-1:0] fix_t;

  // leading zero count, 0..FIX_W
  typedef logic [4:0] lzc_t;

  // normalized magnitude, unsigned 0.20 with the top bit set
  localparam int MANT_W = 20;

  typedef logic [MANT_W-1:0] mant_t;

  // reciprocal mantissa, unsigned Q2.16
  localparam int RECIP_FRAC = 16;

  typedef logic [RECIP_FRAC+1:0] rmant_t;

  // saturation magnitude of the output
  localparam fix_t FIX_MAX = fix_t'((1 << (FIX_W - 1)) - 1);

endpackage
